/* br_settings.svh */
`ifndef BR_SETTINGS_SVH
`define BR_SETTINGS_SVH

// predictor geometry
// index comes from pc just above the word offset, tag right above the index
`define BTB_IDX_BITS 6
`define BTB_TAG_BITS 8
`define BTB_ENTRIES  (1 << `BTB_IDX_BITS)

// uop condition field
`define UOP_COND_BITS 4

`endif

/* core_uop_pkg.sv */
`default_nettype none

`include "br_settings.svh"

package core_uop_pkg;

    // branch condition codes as issued by the decoder
    typedef enum logic [`UOP_COND_BITS-1:0] {
        BR_OTHER = 'd0,  // not a control-flow op
        BR_JIRL  = 'd3,
        BR_B     = 'd4,
        BR_BL    = 'd5,
        BR_BEQ   = 'd6,
        BR_BNE   = 'd7,
        BR_BLT   = 'd8,
        BR_BGE   = 'd9,
        BR_BLTU  = 'd10,
        BR_BGEU  = 'd11
    } br_cond_t;

    typedef struct packed {
        logic        is_branch;
        br_cond_t    cond;
        logic [31:0] pc;
        logic [29:0] imm;   // word offset
        logic [31:0] src1;  // forwarded rj
        logic [31:0] src2;  // forwarded rd
    } ex_uop_t;

endpackage

`default_nettype wire

/* bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    import core_uop_pkg::*;

    // what fetch believed about one pc
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } pred_t;

    // execute stage payload
    typedef struct packed {
        ex_uop_t uop;
        pred_t   pred;
    } ex_entry_t;

    // outcome of one resolved op, also the predictor training record
    typedef struct packed {
        logic        dir_fail;     // direction was wrong
        logic        addr_fail;    // fetch went to the wrong place
        logic        is_branch;
        logic        fact_taken;
        logic [31:0] fact_pc;
        logic [31:0] fact_tpc;     // computed target
        logic [31:0] redirect_pc;  // where fetch has to restart
    } resolve_t;

endpackage

`default_nettype wire

/* stage_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
    parameter type T = logic
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  flush,
    input  wire  in_valid,
    input  wire  T in_data,
    output logic out_valid,
    output T     out_data
);

    logic valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

    // a flush kills the held entry before the next stage samples it
    assign out_valid = valid_q & ~flush;

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid)
    ) else $error("stage_reg: out_valid is unknown");

endmodule

`default_nettype wire

/* ex_branch.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_branch (
    input  wire bpu_pkg::ex_entry_t entry,
    output bpu_pkg::resolve_t       resolved
);

    import core_uop_pkg::*;
    import bpu_pkg::*;

    ex_uop_t     uop;
    pred_t       pred;
    logic        src_eq;
    logic        src_lt_u;
    logic        src_lt_s;
    logic        cond_met;
    logic        taken;
    logic [31:0] offset;
    logic [31:0] target;
    logic [31:0] pc_seq;

    assign uop  = entry.uop;
    assign pred = entry.pred;

    assign src_eq   = (uop.src1 == uop.src2);
    assign src_lt_u = (uop.src1 < uop.src2);
    assign src_lt_s = (uop.src1[31] != uop.src2[31]) ? uop.src1[31] : src_lt_u;

    always_comb begin
        case (uop.cond)
            BR_JIRL, BR_B, BR_BL: cond_met = 1'b1;
            BR_BEQ:               cond_met = src_eq;
            BR_BNE:               cond_met = ~src_eq;
            BR_BLT:               cond_met = src_lt_s;
            BR_BGE:               cond_met = ~src_lt_s;
            BR_BLTU:              cond_met = src_lt_u;
            BR_BGEU:              cond_met = ~src_lt_u;
            default:              cond_met = 1'b0;
        endcase
    end

    assign taken  = uop.is_branch & cond_met;
    assign offset = {uop.imm, 2'b00};
    // jirl is register relative, everything else pc relative
    assign target = (uop.cond == BR_JIRL) ? uop.src1 + offset : uop.pc + offset;
    assign pc_seq = uop.pc + 32'd4;

    always_comb begin
        resolved.dir_fail    = taken ^ pred.taken;
        resolved.addr_fail   = (taken ^ pred.taken) |
                               (taken & pred.taken & (pred.target != target));
        resolved.is_branch   = uop.is_branch;
        resolved.fact_taken  = taken;
        resolved.fact_pc     = uop.pc;
        resolved.fact_tpc    = target;
        resolved.redirect_pc = taken ? target : pc_seq;
    end

endmodule

`default_nettype wire

/* branch_predictor.sv */
`timescale 1ns/1ns
`default_nettype none

`include "br_settings.svh"

module branch_predictor (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [31:0]              fetch_pc,
    output bpu_pkg::pred_t          fetch_pred,
    input  wire                     upd_valid,
    input  wire bpu_pkg::resolve_t  upd
);

    import bpu_pkg::*;

    localparam int IDX_LO = 2;
    localparam int IDX_HI = IDX_LO + `BTB_IDX_BITS - 1;
    localparam int TAG_LO = IDX_HI + 1;
    localparam int TAG_HI = TAG_LO + `BTB_TAG_BITS - 1;

    logic [`BTB_ENTRIES-1:0]  btb_valid;
    logic [`BTB_TAG_BITS-1:0] btb_tag    [`BTB_ENTRIES];
    logic [31:0]              btb_target [`BTB_ENTRIES];
    logic [1:0]               cnt        [`BTB_ENTRIES];

    logic [`BTB_IDX_BITS-1:0] f_idx;
    logic [`BTB_TAG_BITS-1:0] f_tag;
    logic                     f_hit;
    logic [`BTB_IDX_BITS-1:0] u_idx;
    logic [`BTB_TAG_BITS-1:0] u_tag;
    logic                     train;

    // lookup
    assign f_idx = fetch_pc[IDX_HI:IDX_LO];
    assign f_tag = fetch_pc[TAG_HI:TAG_LO];
    assign f_hit = btb_valid[f_idx] && (btb_tag[f_idx] == f_tag);

    always_comb begin
        fetch_pred.taken  = f_hit & cnt[f_idx][1];  // weakly taken or above
        fetch_pred.target = fetch_pred.taken ? btb_target[f_idx] : fetch_pc + 32'd4;
    end

    // update
    assign u_idx = upd.fact_pc[IDX_HI:IDX_LO];
    assign u_tag = upd.fact_pc[TAG_HI:TAG_LO];
    assign train = upd_valid & upd.is_branch;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btb_valid <= '0;
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                cnt[i] <= 2'b01;  // weakly not taken
            end
        end else if (train) begin
            if (upd.fact_taken) begin
                btb_valid[u_idx] <= 1'b1;
                if (cnt[u_idx] != 2'b11) begin
                    cnt[u_idx] <= cnt[u_idx] + 2'd1;
                end
            end else if (cnt[u_idx] != 2'b00) begin
                cnt[u_idx] <= cnt[u_idx] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (train && upd.fact_taken) begin
            btb_tag[u_idx]    <= u_tag;
            btb_target[u_idx] <= upd.fact_tpc;
        end
    end

    // the resolve side must never claim a taken non-branch
    a_upd_taken_branch: assert property (
        @(posedge clk) disable iff (!rst_n)
        upd_valid |-> !(upd.fact_taken && !upd.is_branch)
    ) else $error("branch_predictor: taken update without is_branch");

endmodule

`default_nettype wire

/* branch_unit_top.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_unit_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [31:0]              fetch_pc,
    output bpu_pkg::pred_t          fetch_pred,
    input  wire                     ex_valid,
    input  wire bpu_pkg::ex_entry_t ex_in,
    output logic                    res_valid,
    output bpu_pkg::resolve_t       res,
    output logic                    redirect
);

    import bpu_pkg::*;

    logic      ex_q_valid;
    ex_entry_t ex_q;
    resolve_t  res_d;

    stage_reg #(.T(ex_entry_t)) u_ex_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (redirect),  // younger op behind a mispredict
        .in_valid  (ex_valid),
        .in_data   (ex_in),
        .out_valid (ex_q_valid),
        .out_data  (ex_q)
    );

    ex_branch u_ex_branch (
        .entry    (ex_q),
        .resolved (res_d)
    );

    stage_reg #(.T(resolve_t)) u_res_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (1'b0),
        .in_valid  (ex_q_valid),
        .in_data   (res_d),
        .out_valid (res_valid),
        .out_data  (res)
    );

    assign redirect = res_valid & (res.dir_fail | res.addr_fail);

    branch_predictor u_bpu (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_pc   (fetch_pc),
        .fetch_pred (fetch_pred),
        .upd_valid  (res_valid),
        .upd        (res)
    );

endmodule

`default_nettype wire

/* tb_branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "br_settings.svh"

module tb_branch_unit;

    import core_uop_pkg::*;
    import bpu_pkg::*;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] fetch_pc;
    pred_t       fetch_pred;
    logic        ex_valid;
    ex_entry_t   ex_in;
    logic        res_valid;
    resolve_t    res;
    logic        redirect;

    logic [31:0] lfsr_state = 32'h891b;
    int          mismatches = 0;
    int          other_errors = 0;
    int          dropped = 0;
    int          taken_preds = 0;

    logic                     m_ex_valid;   // reference pipeline
    ex_entry_t                m_ex;
    logic                     m_res_valid;
    resolve_t                 m_res;
    logic                     t_valid  [`BTB_ENTRIES];  // reference predictor tables
    logic [`BTB_TAG_BITS-1:0] t_tag    [`BTB_ENTRIES];
    logic [31:0]              t_target [`BTB_ENTRIES];
    logic [1:0]               t_cnt    [`BTB_ENTRIES];

    branch_unit_top DUT (.*);

    always #5 clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return v;
    endfunction

    // tags 0x10 and 0x30 share indices 0..7
    function automatic logic [31:0] pool_pc();
        return 32'h1000 + (take_bits(1) << 13) + (take_bits(3) << 2);
    endfunction

    function automatic resolve_t resolve_expected(ex_entry_t e);
        resolve_t    r;
        logic        met;
        logic [31:0] base;
        case (e.uop.cond)
            BR_JIRL, BR_B, BR_BL: met = 1'b1;
            BR_BEQ:  met = e.uop.src1 == e.uop.src2;
            BR_BNE:  met = e.uop.src1 != e.uop.src2;
            BR_BLT:  met = $signed(e.uop.src1) < $signed(e.uop.src2);
            BR_BGE:  met = $signed(e.uop.src1) >= $signed(e.uop.src2);
            BR_BLTU: met = e.uop.src1 < e.uop.src2;
            BR_BGEU: met = e.uop.src1 >= e.uop.src2;
            default: met = 1'b0;
        endcase
        base = (e.uop.cond == BR_JIRL) ? e.uop.src1 : e.uop.pc;
        r.is_branch   = e.uop.is_branch;
        r.fact_taken  = e.uop.is_branch && met;
        r.fact_pc     = e.uop.pc;
        r.fact_tpc    = base + {e.uop.imm, 2'b00};
        r.dir_fail    = r.fact_taken != e.pred.taken;
        r.addr_fail   = r.dir_fail || (r.fact_taken && e.pred.target != r.fact_tpc);
        r.redirect_pc = r.fact_taken ? r.fact_tpc : e.uop.pc + 32'd4;
        return r;
    endfunction

    function automatic pred_t lookup_tables(logic [31:0] pc);
        pred_t p;
        p.taken  = t_valid[pc[7:2]] && (t_tag[pc[7:2]] == pc[15:8]) && (t_cnt[pc[7:2]] >= 2);
        p.target = p.taken ? t_target[pc[7:2]] : pc + 32'd4;
        return p;
    endfunction

    task automatic train_tables(resolve_t r);
        if (r.fact_taken) begin
            t_valid[r.fact_pc[7:2]]  = 1'b1;
            t_tag[r.fact_pc[7:2]]    = r.fact_pc[15:8];
            t_target[r.fact_pc[7:2]] = r.fact_tpc;
            if (t_cnt[r.fact_pc[7:2]] < 2'd3) t_cnt[r.fact_pc[7:2]] += 2'd1;
        end else if (t_cnt[r.fact_pc[7:2]] > 2'd0) begin
            t_cnt[r.fact_pc[7:2]] -= 2'd1;
        end
    endtask

    function automatic ex_entry_t random_entry();
        ex_entry_t e;
        resolve_t  r;
        logic [1:0] sel;
        e = '0;
        e.uop.is_branch = take_bits(2) != 0;
        e.uop.cond      = br_cond_t'(4'(take_bits(4)));  // unused codes act as non-branch
        e.uop.pc        = pool_pc();
        e.uop.imm       = 30'(take_bits(30));
        e.uop.src1      = take_bits(32);
        sel             = 2'(take_bits(2));
        e.uop.src2      = (sel == 2'd0) ? e.uop.src1 :
                          (sel == 2'd1) ? e.uop.src1 ^ 32'h8000_0000 : take_bits(32);
        r   = resolve_expected(e);
        sel = 2'(take_bits(2));
        case (sel)
            2'd0: e.pred = lookup_tables(e.uop.pc);
            2'd1: begin  // right direction and right target
                e.pred.taken  = r.fact_taken;
                e.pred.target = r.fact_taken ? r.fact_tpc : e.uop.pc + 32'd4;
            end
            2'd2: begin
                e.pred.taken  = 1'(take_bits(1));
                e.pred.target = r.fact_tpc;
            end
            default: begin
                e.pred.taken  = 1'(take_bits(1));
                e.pred.target = take_bits(32);
            end
        endcase
        return e;
    endfunction

    task automatic report_mismatch(string msg);
        mismatches++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    task automatic report_timeout(string what);
        other_errors++;
        $display("Timed out waiting for %s", what);
    endtask

    // mirrors one rising edge with the inputs driven in the cycle before
    task automatic advance_model();
        logic kill;
        kill = m_res_valid && (m_res.dir_fail || m_res.addr_fail);
        if (m_res_valid && m_res.is_branch) train_tables(m_res);
        if (m_ex_valid && kill) dropped++;
        m_res_valid = m_ex_valid && !kill;
        m_res       = resolve_expected(m_ex);
        m_ex_valid  = ex_valid;
        m_ex        = ex_in;
    endtask

    task automatic compare_outputs();
        pred_t exp_pred;
        logic  exp_redirect;
        exp_pred     = lookup_tables(fetch_pc);
        exp_redirect = m_res_valid && (m_res.dir_fail || m_res.addr_fail);
        assert (res_valid === m_res_valid)
            else report_mismatch($sformatf("res_valid %b, expected %b", res_valid, m_res_valid));
        if (m_res_valid) begin
            assert (res === m_res)
                else report_mismatch($sformatf("res %h, expected %h", res, m_res));
        end
        assert (redirect === exp_redirect)
            else report_mismatch($sformatf("redirect %b, expected %b", redirect, exp_redirect));
        assert (fetch_pred === exp_pred)
            else report_mismatch($sformatf("fetch_pred %h for pc %h, expected %h",
                                           fetch_pred, fetch_pc, exp_pred));
        if (exp_pred.taken) taken_preds++;
    endtask

    task automatic run_cycle();
        @(negedge clk);
        advance_model();
        compare_outputs();
    endtask

    task automatic run_stimulus();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            report_timeout("reset release");
            return;
        end

        run_cycle();  // outputs idle after reset
        run_cycle();
        ex_valid = 1'b1;  // first op, nothing ahead of it
        ex_in    = random_entry();
        n = 0;
        do begin
            run_cycle();
            n++;
            ex_valid = 1'b0;
        end while (!res_valid && n < 8);
        if (!res_valid) begin
            report_timeout("the first result");
            return;
        end
        assert (n == 2)
            else report_mismatch($sformatf("first op took %0d cycles, expected 2", n));

        for (int i = 0; i < 3000; i++) begin
            ex_valid = take_bits(3) != 0;
            ex_in    = random_entry();
            fetch_pc = pool_pc();
            run_cycle();
        end

        ex_valid = 1'b0;
        n = 0;
        while ((m_ex_valid || m_res_valid || res_valid) && n < 10) begin
            run_cycle();
            n++;
        end
        if (m_ex_valid || m_res_valid || res_valid) begin
            report_timeout("the pipeline to drain");
            return;
        end

        assert (dropped > 0) else begin
            other_errors++;
            $display("No op was ever dropped behind a redirect");
        end
        assert (taken_preds > 0) else begin
            other_errors++;
            $display("The predictor never predicted a taken branch");
        end
    endtask

    initial begin
        fetch_pc    = '0;
        ex_valid    = 1'b0;
        ex_in       = '0;
        m_ex_valid  = 1'b0;
        m_ex        = '0;
        m_res_valid = 1'b0;
        m_res       = '0;
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            t_valid[i]  = 1'b0;
            t_tag[i]    = '0;
            t_target[i] = '0;
            t_cnt[i]    = 2'b01;
        end

        run_stimulus();

        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* branch_unit_top.f */
+incdir+.
core_uop_pkg.sv
bpu_pkg.sv
stage_reg.sv
ex_branch.sv
branch_predictor.sv
branch_unit_top.sv
tb_branch_unit.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         ?= tb_branch_unit
FILELIST    ?= branch_unit_top.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
EXTRA_FLAGS ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter %.sv,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(EXTRA_FLAGS) \
		-f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
